// File: src/mem_bus_pkg.sv
/* Memory bus definitions shared by the arbiter, the controller and the line store.
   Import wherever a request, a response or a line is handled. */
package mem_bus_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned LINE_W = 512;

    // The fourth code is reserved and behaves as idle
    typedef enum logic [1:0] {
        op_idle  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2,
        op_rsvd  = 2'd3
    } mem_op_t;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;

    // Held stable by the requester until its tx_done
    typedef struct packed {
        mem_op_t op;
        addr_t   raw_address;
        addr_t   address_offset;
        line_t   wdata;
    } mem_req_t;

    typedef struct packed {
        line_t rdata;
        logic  tx_done;
        logic  rd_valid;
    } mem_rsp_t;

    // True only for codes that start a transfer
    function automatic logic op_active(mem_op_t op);
        return (op == op_read) || (op == op_write);
    endfunction

endpackage

// File: src/arb_pkg.sv
/* Requester identifiers for the shared memory arbiter.
   The enum order is the round-robin grant order. */
package arb_pkg;

    localparam int unsigned NUM_SRC = 4;

    // Also serves as the arbiter grant state
    typedef enum logic [1:0] {
        src_dmem = 2'd0,
        src_imem = 2'd1,
        src_fpu  = 2'd2,
        src_mmio = 2'd3
    } src_id_t;

    // Successor in the rotation, wrapping back to dmem
    function automatic src_id_t next_src(src_id_t cur);
        case (cur)
            src_dmem: return src_imem;
            src_imem: return src_fpu;
            src_fpu:  return src_mmio;
            default:  return src_dmem;
        endcase
    endfunction

endpackage

// File: src/line_store.sv
/* Single-port line memory behind the memory controller.
   Write on we, read data registered and valid one cycle after index. */
`timescale 1ns/100ps

module line_store #(
    parameter int unsigned LINE_COUNT = 64
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(LINE_COUNT)-1:0] index,
    input  mem_bus_pkg::line_t            wdata,
    output mem_bus_pkg::line_t            rdata
);

    import mem_bus_pkg::*;

    // Contents undefined until written
    line_t lines [LINE_COUNT];

    always_ff @(posedge clk) begin
        if (we) begin
            lines[index] <= wdata;
        end
    end

    // Old data on a same-cycle write to the read index
    always_ff @(posedge clk) begin
        rdata <= lines[index];
    end

endmodule

// File: src/mem_ctrl.sv
/* Single-line memory controller with a fixed access latency.
   Accepts one request at a time and pulses tx_done on completion. */
`timescale 1ns/100ps

module mem_ctrl #(
    parameter int unsigned ACCESS_LATENCY = 3,
    parameter int unsigned LINE_COUNT     = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_bus_pkg::mem_req_t ctrl_req,
    output mem_bus_pkg::mem_rsp_t ctrl_rsp
);

    import mem_bus_pkg::*;

    localparam int unsigned IDX_W = $clog2(LINE_COUNT);
    // Wide enough to hold ACCESS_LATENCY - 1 even when the latency is 1
    localparam int unsigned CNT_W = $clog2(ACCESS_LATENCY + 1);

    typedef enum logic {
        st_idle,
        st_busy
    } ctrl_state_t;

    ctrl_state_t      state_q;
    logic [CNT_W-1:0] cnt_q;
    mem_req_t         req_q;

    logic             done;
    logic             rd_valid;
    logic             store_we;
    logic [IDX_W-1:0] store_index;
    line_t            store_rdata;

    // Line index is the sum of raw address and offset, modulo LINE_COUNT
    function automatic logic [IDX_W-1:0] line_index(mem_req_t req);
        addr_t sum;
        sum = req.raw_address + req.address_offset;
        return sum[IDX_W-1:0];
    endfunction

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (op_active(ctrl_req.op)) begin
                        state_q <= st_busy;
                        cnt_q   <= CNT_W'(ACCESS_LATENCY - 1);
                    end
                end
                default: begin
                    // Op seen during the done cycle belongs to the next grant
                    if (done) begin
                        state_q <= st_idle;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
            endcase
        end
    end

    // Request payload captured at acceptance
    always_ff @(posedge clk) begin
        if (state_q == st_idle && op_active(ctrl_req.op)) begin
            req_q <= ctrl_req;
        end
    end

    assign done     = (state_q == st_busy) && (cnt_q == '0);
    assign rd_valid = done && (req_q.op == op_read);
    assign store_we = done && (req_q.op == op_write);

    // Live index while idle so a latency of one still has rdata on time
    assign store_index = (state_q == st_busy) ? line_index(req_q) : line_index(ctrl_req);

    always_comb begin
        ctrl_rsp          = '0;
        ctrl_rsp.tx_done  = done;
        ctrl_rsp.rd_valid = rd_valid;
        if (rd_valid) begin
            ctrl_rsp.rdata = store_rdata;
        end
    end

    line_store #(
        .LINE_COUNT (LINE_COUNT)
    ) u_store (
        .clk   (clk),
        .we    (store_we),
        .index (store_index),
        .wdata (req_q.wdata),
        .rdata (store_rdata)
    );

endmodule

// File: src/mem_arbiter.sv
/* Round-robin arbiter placing four requesters on one memory controller.
   A grant is held until the granted op completes or goes idle. */
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  mem_bus_pkg::mem_req_t [arb_pkg::NUM_SRC-1:0] src_req,
    output mem_bus_pkg::mem_rsp_t [arb_pkg::NUM_SRC-1:0] src_rsp,
    output mem_bus_pkg::mem_req_t                         ctrl_req,
    input  mem_bus_pkg::mem_rsp_t                         ctrl_rsp
);

    import mem_bus_pkg::*;
    import arb_pkg::*;

    src_id_t  grant_q;
    src_id_t  grant_d;
    mem_req_t granted_req;
    logic     hold;

    // Requests stay up until done, so the arbiter never stores them
    assign granted_req = src_req[grant_q];

    // Stay only while a real op is pending and not finishing now
    assign hold = op_active(granted_req.op) && !ctrl_rsp.tx_done;

    always_comb begin
        grant_d = grant_q;
        if (!hold) begin
            grant_d = next_src(grant_q);
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= src_dmem;
        end else begin
            grant_q <= grant_d;
        end
    end

    // Request mux toward the controller
    always_comb begin
        ctrl_req = '0;
        case (grant_q)
            src_dmem: ctrl_req = src_req[src_dmem];
            src_imem: ctrl_req = src_req[src_imem];
            src_fpu:  ctrl_req = src_req[src_fpu];
            src_mmio: ctrl_req = src_req[src_mmio];
            default:  ctrl_req = '0;
        endcase
    end

    // Response demux; ungranted sources read all zeros
    always_comb begin
        src_rsp = '0;
        case (grant_q)
            src_dmem: src_rsp[src_dmem] = ctrl_rsp;
            src_imem: src_rsp[src_imem] = ctrl_rsp;
            src_fpu:  src_rsp[src_fpu]  = ctrl_rsp;
            src_mmio: src_rsp[src_mmio] = ctrl_rsp;
            default:  src_rsp = '0;
        endcase
    end

endmodule

// File: src/mem_subsys_top.sv
/* Shared memory subsystem: four requesters, arbiter, controller and line store.
   Parameters set here reach the controller and the store. */
`timescale 1ns/100ps

module mem_subsys_top #(
    parameter int unsigned ACCESS_LATENCY = 3,
    parameter int unsigned LINE_COUNT     = 64
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  mem_bus_pkg::mem_req_t [arb_pkg::NUM_SRC-1:0] src_req,
    output mem_bus_pkg::mem_rsp_t [arb_pkg::NUM_SRC-1:0] src_rsp
);

    import mem_bus_pkg::*;

    // Granted request and its response
    mem_req_t ctrl_req;
    mem_rsp_t ctrl_rsp;

    mem_arbiter u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .src_req  (src_req),
        .src_rsp  (src_rsp),
        .ctrl_req (ctrl_req),
        .ctrl_rsp (ctrl_rsp)
    );

    // Controller owns the line store
    mem_ctrl #(
        .ACCESS_LATENCY (ACCESS_LATENCY),
        .LINE_COUNT     (LINE_COUNT)
    ) u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl_req (ctrl_req),
        .ctrl_rsp (ctrl_rsp)
    );

endmodule

// File: dv/mem_subsys_properties.sv
/* Concurrent assertions for the shared memory subsystem, bound to its top level.
   Covers reset quiet, completion pulses, response routing, grant rotation and service bound. */
`timescale 1ns/100ps

module mem_subsys_properties #(
    parameter int unsigned ACCESS_LATENCY = 3
) (
    input logic                                          clk,
    input logic                                          rst_n,
    input mem_bus_pkg::mem_req_t [arb_pkg::NUM_SRC-1:0] src_req,
    input mem_bus_pkg::mem_rsp_t [arb_pkg::NUM_SRC-1:0] src_rsp
);

    import mem_bus_pkg::*;
    import arb_pkg::*;

    localparam int unsigned SERVICE_BOUND = NUM_SRC * (ACCESS_LATENCY + 2);

    logic [NUM_SRC-1:0] done_vec;
    logic [NUM_SRC-1:0] valid_vec;
    logic [NUM_SRC-1:0] active_vec;
    logic [NUM_SRC-1:0] read_vec;
    src_id_t            done_src;
    src_id_t            prev_src;
    logic               all_active_q;
    int unsigned        wait_cnt [NUM_SRC];
    logic               violation_seen = 1'b0;

    always_comb begin
        done_src = src_dmem;
        for (int i = 0; i < NUM_SRC; i++) begin
            done_vec[i]   = src_rsp[i].tx_done;
            valid_vec[i]  = src_rsp[i].rd_valid;
            active_vec[i] = (src_req[i].op == op_read) || (src_req[i].op == op_write);
            read_vec[i]   = (src_req[i].op == op_read);
            if (src_rsp[i].tx_done) begin
                done_src = src_id_t'(i[1:0]);
            end
        end
    end

    // Window since the last completion in which all four requests stayed up
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            prev_src     <= src_dmem;
            all_active_q <= 1'b0;
        end else if (done_vec != '0) begin
            prev_src     <= done_src;
            all_active_q <= 1'b1;
        end else begin
            all_active_q <= all_active_q && (&active_vec);
        end
    end

    // Cycles each pending request has waited
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                wait_cnt[i] <= 0;
            end
        end else begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (done_vec[i] || !active_vec[i]) begin
                    wait_cnt[i] <= 0;
                end else begin
                    wait_cnt[i] <= wait_cnt[i] + 1;
                end
            end
        end
    end

    reset_quiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (done_vec == '0 && valid_vec == '0))
        else begin
            violation_seen = 1'b1;
            $error("completion signalled during reset or in the first cycle after it");
        end

    one_completion: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(done_vec))
        else begin
            violation_seen = 1'b1;
            $error("more than one source saw tx_done in the same cycle");
        end

    // Grant order follows the source numbering and wraps after mmio
    rotation: assert property (@(posedge clk) disable iff (!rst_n)
        (done_vec != '0 && all_active_q && (&active_vec))
        |-> (done_src == src_id_t'((int'(prev_src) + 1) % NUM_SRC)))
        else begin
            violation_seen = 1'b1;
            $error("completion order broke the round-robin rotation");
        end

    for (genvar g = 0; g < NUM_SRC; g++) begin : g_src_props
        valid_routing: assert property (@(posedge clk) disable iff (!rst_n)
            valid_vec[g] |-> (done_vec[g] && $past(read_vec[g])))
            else begin
                violation_seen = 1'b1;
                $error("rd_valid without tx_done on a pending read");
            end

        single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            done_vec[g] |=> !done_vec[g])
            else begin
                violation_seen = 1'b1;
                $error("tx_done held longer than one cycle");
            end

        service_bound: assert property (@(posedge clk) disable iff (!rst_n)
            wait_cnt[g] <= SERVICE_BOUND)
            else begin
                violation_seen = 1'b1;
                $error("pending request not served within the arbitration bound");
            end
    end

endmodule

// File: dv/tb_mem_subsys.sv
/* Testbench for the shared memory subsystem with four random requesters.
   Compiled from the project root through the file list; bound properties check the protocol. */
`timescale 1ns/100ps

module tb_mem_subsys;

    import mem_bus_pkg::*;
    import arb_pkg::*;

    localparam int unsigned ACCESS_LATENCY  = 3;
    localparam int unsigned LINE_COUNT      = 64;
    localparam int unsigned SEED            = 63411;
    localparam int unsigned CLK_HALF        = 10;
    localparam int unsigned RESET_CYCLES    = 16;
    localparam int unsigned N_ROTATE        = 24;
    localparam int unsigned N_GAPS          = 16;
    localparam int unsigned HOT_LINES       = 8;
    localparam int unsigned MAX_GAP         = 5;
    localparam int unsigned TOTAL_REQ       = LINE_COUNT + NUM_SRC * (N_ROTATE + N_GAPS);
    localparam int unsigned WATCHDOG_CYCLES =
        TOTAL_REQ * NUM_SRC * (ACCESS_LATENCY + 2) + 100;

    localparam int unsigned PH_RESET  = 0;
    localparam int unsigned PH_FILL   = 1;
    localparam int unsigned PH_ROTATE = 2;
    localparam int unsigned PH_GAPS   = 3;

    logic                   clk;
    logic                   rst_n;
    wire mem_req_t [NUM_SRC-1:0] src_req;
    mem_rsp_t [NUM_SRC-1:0] src_rsp;

    // Expected contents updated when a write completes
    line_t       model [LINE_COUNT];
    int unsigned phase;
    int unsigned reached [NUM_SRC];

    mem_subsys_top #(
        .ACCESS_LATENCY (ACCESS_LATENCY),
        .LINE_COUNT     (LINE_COUNT)
    ) DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .src_req (src_req),
        .src_rsp (src_rsp)
    );

    bind mem_subsys_top mem_subsys_properties #(
        .ACCESS_LATENCY (ACCESS_LATENCY)
    ) u_props (
        .clk     (clk),
        .rst_n   (rst_n),
        .src_req (src_req),
        .src_rsp (src_rsp)
    );

    function automatic line_t rand_line();
        line_t line;
        for (int w = 0; w < LINE_W / 32; w++) begin
            line[w*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    // Reserved op code with junk fields must look idle to the arbiter
    function automatic mem_req_t idle_request();
        mem_req_t r;
        r = '0;
        if ($urandom_range(1, 0) == 1) begin
            r.op             = op_rsvd;
            r.raw_address    = $urandom;
            r.address_offset = $urandom;
        end
        return r;
    endfunction

    function automatic logic all_reached(int unsigned p);
        for (int i = 0; i < NUM_SRC; i++) begin
            if (reached[i] < p) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: requests still pending after %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1);
    end

    always @(negedge clk) begin
        if (DUT.u_props.violation_seen) begin
            $display("A bound protocol assertion failed");
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    for (genvar g = 0; g < NUM_SRC; g++) begin : g_src
        mem_req_t req;

        assign src_req[g] = req;

        // Holds one request until its tx_done, then checks or records the line
        task automatic issue_request(input mem_op_t op, input int unsigned idx,
                                     input string test_name);
            mem_req_t r;
            addr_t    raw;
            line_t    expected;
            raw              = $urandom;
            r.op             = op;
            r.raw_address    = raw;
            // Sum lands on idx plus a random multiple of LINE_COUNT
            r.address_offset = addr_t'(idx) + addr_t'($urandom_range(1023, 0) * LINE_COUNT)
                               - raw;
            r.wdata          = rand_line();
            req              = r;
            @(negedge clk);
            while (!src_rsp[g].tx_done) begin
                @(negedge clk);
            end
            if (op == op_write) begin
                model[idx] = r.wdata;
            end else begin
                if (!src_rsp[g].rd_valid) begin
                    $display("Read by source %0d at line %0d completed without rd_valid",
                             g, idx);
                    $display("RESULT: FAIL");
                    $fatal(1);
                end
                expected = model[idx];
                assert (src_rsp[g].rdata == expected) else begin
                    $display("CHECK FAILED %s: source %0d line %0d expected %h actual %h",
                             test_name, g, idx, expected, src_rsp[g].rdata);
                    $display("RESULT: FAIL");
                    $fatal(1);
                end
            end
        endtask

        initial begin : requester
            mem_op_t     op;
            int unsigned gap;
            req        = '0;
            reached[g] = PH_RESET;

            wait (phase == PH_FILL);
            // dmem alone so the other grants are skipped
            if (g == 0) begin
                for (int unsigned i = 0; i < LINE_COUNT; i++) begin
                    issue_request(op_write, i, "fill");
                end
            end
            req        = '0;
            reached[g] = PH_FILL;

            wait (phase == PH_ROTATE);
            // No idle cycle between requests
            for (int n = 0; n < N_ROTATE; n++) begin
                op = ($urandom_range(1, 0) == 1) ? op_write : op_read;
                issue_request(op, $urandom_range(LINE_COUNT - 1, 0), "rotation");
            end
            req        = '0;
            reached[g] = PH_ROTATE;

            wait (phase == PH_GAPS);
            // Small hot set so sources read each other's writes
            for (int n = 0; n < N_GAPS; n++) begin
                op = ($urandom_range(1, 0) == 1) ? op_write : op_read;
                issue_request(op, $urandom_range(HOT_LINES - 1, 0), "gaps");
                req = idle_request();
                gap = $urandom_range(MAX_GAP, 0);
                repeat (gap) @(negedge clk);
            end
            req        = '0;
            reached[g] = PH_GAPS;
        end
    end

    initial begin : main
        void'($urandom(SEED));
        rst_n = 1'b0;
        phase = PH_RESET;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        for (int unsigned p = PH_FILL; p <= PH_GAPS; p++) begin
            phase = p;
            while (!all_reached(p)) begin
                @(negedge clk);
            end
        end

        repeat (4) @(negedge clk);
        if (DUT.u_props.violation_seen) begin
            $display("A bound protocol assertion failed");
            $display("RESULT: FAIL");
            $fatal(1);
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: filelist.f
src/mem_bus_pkg.sv
src/arb_pkg.sv
src/line_store.sv
src/mem_ctrl.sv
src/mem_arbiter.sv
src/mem_subsys_top.sv
dv/mem_subsys_properties.sv
dv/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_subsys -f filelist.f -o sim_mem_subsys &&
./obj_dir/sim_mem_subsys +verilator+error+limit+100 ||
{ echo "Simulation build or run failed" >&2; exit 1; }
